//--- rtl/hist_pkg.sv
package hist_pkg;

    // lane sequencing
    // ACCUM takes photons, DRAIN streams the histogram out,
    // CLEAN is the one cycle that ages all touched tags
    typedef enum logic [1:0] {
        ACCUM = 2'b00,
        DRAIN = 2'b01,
        CLEAN = 2'b10
    } lane_state_e;

    // readout sequencing
    // idle until lane 0 offers its first word
    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } readout_state_e;

    // default geometry
    // pixels must divide evenly over the lanes
    localparam int DEF_N_LANES = 2;

    // arrival bins per pixel, power of two
    localparam int DEF_BINS = 8;

    // pixels per frame
    localparam int DEF_PIXELS = 4;

    // photons per pixel before moving on
    localparam int DEF_SAMPLES_PER_PIXEL = 3;

    // frames per histogram period
    localparam int DEF_FRAMES = 3;

    // count width, saturates at all ones
    localparam int DEF_COUNT_W = 3;

endpackage

//--- rtl/hist_if.sv
// photon write into one lane
interface lane_wr_if #(
    parameter int BIN_W = 3,
    parameter int PIX_W = 1
);
    logic             valid;
    logic             ready;
    logic [BIN_W-1:0] bin;
    logic [PIX_W-1:0] pix;
    // closing transfer of a period, seen by every lane
    logic             period_end;

    modport src (output valid, bin, pix, period_end, input ready);
    modport dst (input valid, bin, pix, period_end, output ready);
endinterface

// drained bins out of one lane
interface lane_rd_if #(
    parameter int BIN_W = 3,
    parameter int PIX_W = 1,
    parameter int CNT_W = 3
);
    logic             valid;
    logic             ready;
    logic [PIX_W-1:0] pix;
    logic [BIN_W-1:0] bin;
    logic [CNT_W-1:0] count;
    // final bin of this lane
    logic             last;

    modport src (output valid, pix, bin, count, last, input ready);
    modport dst (input valid, pix, bin, count, last, output ready);
endinterface

//--- rtl/photon_dispatch.sv
module photon_dispatch #(
    parameter int N_LANES = 2,
    parameter int BINS = 8,
    parameter int PIXELS = 4,
    parameter int SAMPLES_PER_PIXEL = 3,
    parameter int FRAMES = 3,
    localparam int BIN_W = $clog2(BINS)
) (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             photon_valid,
    output logic             photon_ready,
    input  logic [BIN_W-1:0] photon_bin,
    lane_wr_if.src           lane [N_LANES]
);
    localparam int LPIX = PIXELS / N_LANES;
    localparam int LPIX_W = (LPIX > 1) ? $clog2(LPIX) : 1;
    localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;
    localparam int SMP_W = (SAMPLES_PER_PIXEL > 1) ? $clog2(SAMPLES_PER_PIXEL) : 1;
    localparam int FRM_W = (FRAMES > 1) ? $clog2(FRAMES) : 1;

    // pixel counter kept split as lane index and local pixel
    logic [SMP_W-1:0]   smp;
    logic [LANE_W-1:0]  lane_idx;
    logic [LPIX_W-1:0]  loc_pix;
    logic [FRM_W-1:0]   frm;
    logic [N_LANES-1:0] lane_ready;
    logic               fire;
    logic               last_smp;
    logic               last_lane;
    logic               last_lpix;
    logic               last_frm;
    logic               period_end;

    assign last_smp = (smp == SMP_W'(SAMPLES_PER_PIXEL - 1));
    assign last_lane = (lane_idx == LANE_W'(N_LANES - 1));
    assign last_lpix = (loc_pix == LPIX_W'(LPIX - 1));
    assign last_frm = (frm == FRM_W'(FRAMES - 1));
    assign period_end = last_smp && last_lane && last_lpix && last_frm;

    // handshake follows the lane that owns the current pixel
    assign photon_ready = lane_ready[lane_idx];
    assign fire = photon_valid && photon_ready;

    for (genvar g = 0; g < N_LANES; g++) begin : g_route
        // valid only towards the owning lane
        assign lane[g].valid = photon_valid && (lane_idx == LANE_W'(g));
        assign lane[g].bin = photon_bin;
        assign lane[g].pix = loc_pix;
        // broadcast so that all lanes stop together
        assign lane[g].period_end = period_end && fire;
        assign lane_ready[g] = lane[g].ready;
    end

    // nested sample, pixel, frame counting
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            smp <= '0;
            lane_idx <= '0;
            loc_pix <= '0;
            frm <= '0;
        end else if (fire) begin
            if (last_smp) begin
                smp <= '0;
                if (last_lane) begin
                    lane_idx <= '0;
                    if (last_lpix) begin
                        loc_pix <= '0;
                        // frame wrap closes the period
                        frm <= last_frm ? '0 : frm + 1'b1;
                    end else begin
                        loc_pix <= loc_pix + 1'b1;
                    end
                end else begin
                    lane_idx <= lane_idx + 1'b1;
                end
            end else begin
                smp <= smp + 1'b1;
            end
        end
    end

endmodule

//--- rtl/hist_lane.sv
module hist_lane
    import hist_pkg::*;
#(
    parameter int N_LANES = 2,
    parameter int BINS = 8,
    parameter int PIXELS = 4,
    parameter int COUNT_W = 3
) (
    input  logic   clk,
    input  logic   combin_res,
    lane_wr_if.dst wr,
    lane_rd_if.src rd
);
    localparam int LPIX = PIXELS / N_LANES;
    localparam int BIN_W = $clog2(BINS);
    localparam int PIX_W = (LPIX > 1) ? $clog2(LPIX) : 1;
    localparam int ADDR_W = PIX_W + BIN_W;
    localparam int DEPTH = LPIX * BINS;

    lane_state_e        state;
    // a bin counts as touched when its tag equals the period bit
    logic               period;
    logic [DEPTH-1:0]   tag;
    logic [COUNT_W-1:0] mem [DEPTH];

    // second stage of the read-modify-write
    logic               wv_q;
    logic [ADDR_W-1:0]  wa_q;
    logic [COUNT_W-1:0] rd_q;
    logic               rt_q;
    logic [COUNT_W-1:0] new_val;

    // drain sequencer and holding register
    logic [ADDR_W-1:0]  ra;
    logic               issued_all;
    logic               issue;
    logic               out_v;
    logic [ADDR_W-1:0]  out_addr;
    logic [COUNT_W-1:0] out_count;
    logic               out_last;

    // shared read port
    logic               wr_fire;
    logic [ADDR_W-1:0]  rd_addr;
    logic               fwd;
    logic [COUNT_W-1:0] rd_cnt;
    logic               rd_hit;

    assign wr.ready = (state == ACCUM);
    assign wr_fire = wr.valid && wr.ready;

    // first hit writes 1, later hits saturate at all ones
    assign new_val = !rt_q ? COUNT_W'(1) : ((&rd_q) ? rd_q : rd_q + 1'b1);

    // photon address while accumulating, drain pointer otherwise
    assign rd_addr = (state == ACCUM) ? {wr.pix, wr.bin} : ra;
    // pending write to the same bin wins over the array
    assign fwd = wv_q && (wa_q == rd_addr);
    assign rd_cnt = fwd ? new_val : mem[rd_addr];
    assign rd_hit = fwd || (tag[rd_addr] == period);

    // next drain read only when the holding register frees up
    assign issue = (state == DRAIN) && !issued_all && (!out_v || rd.ready);

    assign rd.valid = out_v;
    assign rd.pix = out_addr[ADDR_W-1:BIN_W];
    assign rd.bin = out_addr[BIN_W-1:0];
    assign rd.count = out_count;
    assign rd.last = out_last;

    always_ff @(posedge clk) begin
        if (wv_q) begin
            mem[wa_q] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            wa_q <= rd_addr;
            rd_q <= rd_cnt;
            rt_q <= rd_hit;
        end
        if (issue) begin
            out_addr <= ra;
            // untouched bins drain as zero
            out_count <= rd_hit ? rd_cnt : '0;
            out_last <= (ra == ADDR_W'(DEPTH - 1));
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= ACCUM;
            // tags clear to 0, so every bin starts untouched
            period <= 1'b1;
            tag <= '0;
            wv_q <= 1'b0;
            ra <= '0;
            issued_all <= 1'b0;
            out_v <= 1'b0;
        end else begin
            wv_q <= wr_fire;
            if (wv_q) begin
                tag[wa_q] <= period;
            end
            case (state)
                ACCUM: begin
                    if (wr.period_end) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (issue) begin
                        // stamp every drained bin, the flip then ages all of them
                        tag[ra] <= period;
                        if (ra == ADDR_W'(DEPTH - 1)) begin
                            issued_all <= 1'b1;
                        end else begin
                            ra <= ra + 1'b1;
                        end
                    end
                    if (issue) begin
                        out_v <= 1'b1;
                    end else if (rd.ready) begin
                        out_v <= 1'b0;
                    end
                    if (out_v && out_last && rd.ready) begin
                        state <= CLEAN;
                    end
                end
                CLEAN: begin
                    period <= ~period;
                    ra <= '0;
                    issued_all <= 1'b0;
                    state <= ACCUM;
                end
                default: begin
                    state <= ACCUM;
                end
            endcase
        end
    end

endmodule

//--- rtl/hist_readout.sv
module hist_readout
    import hist_pkg::*;
#(
    parameter int N_LANES = 2,
    parameter int BINS = 8,
    parameter int PIXELS = 4,
    parameter int COUNT_W = 3,
    localparam int BIN_W = $clog2(BINS),
    localparam int GPIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    lane_rd_if.dst             lanes [N_LANES],
    output logic               hist_valid,
    input  logic               hist_ready,
    output logic [GPIX_W-1:0]  hist_pixel,
    output logic [BIN_W-1:0]   hist_bin,
    output logic [COUNT_W-1:0] hist_count,
    output logic               hist_last,
    output logic               hist_num
);
    localparam int LPIX = PIXELS / N_LANES;
    localparam int LPIX_W = (LPIX > 1) ? $clog2(LPIX) : 1;
    localparam int SEL_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    readout_state_e     state;
    logic [SEL_W-1:0]   sel;
    logic [N_LANES-1:0] lane_valid;
    logic [N_LANES-1:0] lane_last;
    logic [LPIX_W-1:0]  lane_pix [N_LANES];
    logic [BIN_W-1:0]   lane_bin [N_LANES];
    logic [COUNT_W-1:0] lane_cnt [N_LANES];
    logic               in_fire;
    logic [GPIX_W-1:0]  in_pixel;
    logic               in_last;
    logic               out_take;
    // skid slot, fills only when the output stalls
    logic               skid_v;
    logic [GPIX_W-1:0]  skid_pixel;
    logic [BIN_W-1:0]   skid_bin;
    logic [COUNT_W-1:0] skid_count;
    logic               skid_last;

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        assign lane_valid[g] = lanes[g].valid;
        assign lane_last[g] = lanes[g].last;
        assign lane_pix[g] = lanes[g].pix;
        assign lane_bin[g] = lanes[g].bin;
        assign lane_cnt[g] = lanes[g].count;
        // only the served lane sees ready
        assign lanes[g].ready = (state == SEND) && (sel == SEL_W'(g)) && !skid_v;
    end

    assign in_fire = (state == SEND) && lane_valid[sel] && !skid_v;
    // global pixel from local pixel and lane index
    assign in_pixel = GPIX_W'(lane_pix[sel]) * GPIX_W'(N_LANES) + GPIX_W'(sel);
    assign in_last = lane_last[sel] && (sel == SEL_W'(N_LANES - 1));
    assign out_take = !hist_valid || hist_ready;

    always_ff @(posedge clk) begin
        if (out_take) begin
            if (skid_v) begin
                hist_pixel <= skid_pixel;
                hist_bin <= skid_bin;
                hist_count <= skid_count;
            end else if (in_fire) begin
                hist_pixel <= in_pixel;
                hist_bin <= lane_bin[sel];
                hist_count <= lane_cnt[sel];
            end
        end else if (in_fire) begin
            skid_pixel <= in_pixel;
            skid_bin <= lane_bin[sel];
            skid_count <= lane_cnt[sel];
            skid_last <= in_last;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= IDLE;
            sel <= '0;
            skid_v <= 1'b0;
            hist_valid <= 1'b0;
            hist_last <= 1'b0;
            hist_num <= 1'b0;
        end else begin
            if (out_take) begin
                if (skid_v) begin
                    hist_valid <= 1'b1;
                    hist_last <= skid_last;
                    skid_v <= 1'b0;
                end else begin
                    hist_valid <= in_fire;
                    hist_last <= in_fire && in_last;
                end
            end else if (in_fire) begin
                skid_v <= 1'b1;
            end
            // period toggle on the closing word
            if (hist_valid && hist_ready && hist_last) begin
                hist_num <= ~hist_num;
            end
            case (state)
                IDLE: begin
                    if (lane_valid[0]) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (in_fire && lane_last[sel]) begin
                        if (sel == SEL_W'(N_LANES - 1)) begin
                            sel <= '0;
                            state <= IDLE;
                        end else begin
                            sel <= sel + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/hist_top.sv
module hist_top
    import hist_pkg::*;
#(
    parameter int N_LANES = DEF_N_LANES,
    parameter int BINS = DEF_BINS,
    parameter int PIXELS = DEF_PIXELS,
    parameter int SAMPLES_PER_PIXEL = DEF_SAMPLES_PER_PIXEL,
    parameter int FRAMES = DEF_FRAMES,
    parameter int COUNT_W = DEF_COUNT_W,
    localparam int BIN_W = $clog2(BINS),
    localparam int GPIX_W = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  logic               clk,
    input  logic               combin_res,
    input  logic               photon_valid,
    output logic               photon_ready,
    input  logic [BIN_W-1:0]   photon_bin,
    output logic               hist_valid,
    input  logic               hist_ready,
    output logic [GPIX_W-1:0]  hist_pixel,
    output logic [BIN_W-1:0]   hist_bin,
    output logic [COUNT_W-1:0] hist_count,
    output logic               hist_last,
    output logic               hist_num
);
    localparam int LPIX = PIXELS / N_LANES;
    localparam int LPIX_W = (LPIX > 1) ? $clog2(LPIX) : 1;

    // one write and one drain bus per lane
    lane_wr_if #(.BIN_W(BIN_W), .PIX_W(LPIX_W)) wr_bus [N_LANES] ();
    lane_rd_if #(.BIN_W(BIN_W), .PIX_W(LPIX_W), .CNT_W(COUNT_W)) rd_bus [N_LANES] ();

    photon_dispatch #(
        .N_LANES(N_LANES),
        .BINS(BINS),
        .PIXELS(PIXELS),
        .SAMPLES_PER_PIXEL(SAMPLES_PER_PIXEL),
        .FRAMES(FRAMES)
    ) u_dispatch (
        .clk(clk),
        .combin_res(combin_res),
        .photon_valid(photon_valid),
        .photon_ready(photon_ready),
        .photon_bin(photon_bin),
        .lane(wr_bus)
    );

    // global pixel p lands in lane p mod N_LANES
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        hist_lane #(
            .N_LANES(N_LANES),
            .BINS(BINS),
            .PIXELS(PIXELS),
            .COUNT_W(COUNT_W)
        ) u_lane (
            .clk(clk),
            .combin_res(combin_res),
            .wr(wr_bus[g]),
            .rd(rd_bus[g])
        );
    end

    hist_readout #(
        .N_LANES(N_LANES),
        .BINS(BINS),
        .PIXELS(PIXELS),
        .COUNT_W(COUNT_W)
    ) u_readout (
        .clk(clk),
        .combin_res(combin_res),
        .lanes(rd_bus),
        .hist_valid(hist_valid),
        .hist_ready(hist_ready),
        .hist_pixel(hist_pixel),
        .hist_bin(hist_bin),
        .hist_count(hist_count),
        .hist_last(hist_last),
        .hist_num(hist_num)
    );

endmodule

//--- testbench/tb_clkgen.sv
module tb_clkgen (
    output logic clk,
    output logic combin_res
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset low for two rising edges, released on a falling edge
    initial begin
        combin_res = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;
    end

endmodule

//--- testbench/hist_assert.sv
module hist_assert #(
    parameter int BIN_W = 3,
    parameter int GPIX_W = 2,
    parameter int COUNT_W = 3
) (
    input logic               clk,
    input logic               combin_res,
    input logic               photon_valid,
    input logic               photon_ready,
    input logic [BIN_W-1:0]   photon_bin,
    input logic               period_end,
    input logic               hist_valid,
    input logic               hist_ready,
    input logic [GPIX_W-1:0]  hist_pixel,
    input logic [BIN_W-1:0]   hist_bin,
    input logic [COUNT_W-1:0] hist_count,
    input logic               hist_last
);
    timeunit 1ns;
    timeprecision 1ps;

    // read back by the testbench at the end of the run
    int fail_cnt = 0;

    // photon held with its bin until taken
    a_bin_hold: assert property (@(posedge clk) disable iff (!combin_res)
        photon_valid && !photon_ready |=> photon_valid && $stable(photon_bin))
    else begin
        $error("photon dropped or bin changed before acceptance");
        fail_cnt++;
    end

    // output word frozen under back-pressure
    a_out_hold: assert property (@(posedge clk) disable iff (!combin_res)
        hist_valid && !hist_ready |=> hist_valid &&
        $stable({hist_pixel, hist_bin, hist_count, hist_last}))
    else begin
        $error("output word changed while hist_ready was low");
        fail_cnt++;
    end

    a_reset_quiet: assert property (@(posedge clk) !combin_res |-> !hist_valid)
    else begin
        $error("hist_valid high during reset");
        fail_cnt++;
    end

    // lanes stop right after the closing photon
    a_stall: assert property (@(posedge clk) disable iff (!combin_res)
        photon_valid && photon_ready && period_end |=> !photon_ready)
    else begin
        $error("photon_ready high in the cycle after the closing photon");
        fail_cnt++;
    end

endmodule

bind hist_top hist_assert #(
    .BIN_W(BIN_W),
    .GPIX_W(GPIX_W),
    .COUNT_W(COUNT_W)
) u_hist_assert (
    .clk(clk),
    .combin_res(combin_res),
    .photon_valid(photon_valid),
    .photon_ready(photon_ready),
    .photon_bin(photon_bin),
    .period_end(u_dispatch.period_end),
    .hist_valid(hist_valid),
    .hist_ready(hist_ready),
    .hist_pixel(hist_pixel),
    .hist_bin(hist_bin),
    .hist_count(hist_count),
    .hist_last(hist_last)
);

//--- testbench/hist_tb.sv
module hist_tb
    import hist_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_LANES = DEF_N_LANES;
    localparam int BINS = DEF_BINS;
    localparam int PIXELS = DEF_PIXELS;
    localparam int SPP = DEF_SAMPLES_PER_PIXEL;
    localparam int FRAMES = DEF_FRAMES;
    localparam int COUNT_W = DEF_COUNT_W;
    localparam int BIN_W = $clog2(BINS);
    localparam int GPIX_W = $clog2(PIXELS);
    localparam int LPIX = PIXELS / N_LANES;
    localparam int PER_FRAME = PIXELS * SPP;
    localparam int PER_PERIOD = PER_FRAME * FRAMES;
    localparam int WORDS = PIXELS * BINS;
    localparam int MAX_CNT = (1 << COUNT_W) - 1;
    // 6 periods of slow photons, slow drain and slack
    localparam int TIMEOUT = 2000;
    localparam int unsigned SEED = 32'h166af142;
    // bin patterns
    localparam int MODE_RAMP = 0;
    localparam int MODE_NARROW = 1;
    localparam int MODE_SAT = 2;
    localparam int MODE_RAND = 3;

    logic               clk;
    logic               combin_res;
    logic               photon_valid;
    logic               photon_ready;
    logic [BIN_W-1:0]   photon_bin;
    logic               hist_valid;
    logic               hist_ready;
    logic [GPIX_W-1:0]  hist_pixel;
    logic [BIN_W-1:0]   hist_bin;
    logic [COUNT_W-1:0] hist_count;
    logic               hist_last;
    logic               hist_num;

    // running period, snapshot of the closed period, last drained values
    int          model [PIXELS][BINS];
    int          expect_hist [PIXELS][BINS];
    int          got [PIXELS][BINS];
    int          smp_idx;
    logic        exp_num;
    int          value_errs;
    int          other_errs;
    int          cycles = 0;

    tb_clkgen u_clkgen (
        .clk(clk),
        .combin_res(combin_res)
    );

    hist_top #(
        .N_LANES(N_LANES),
        .BINS(BINS),
        .PIXELS(PIXELS),
        .SAMPLES_PER_PIXEL(SPP),
        .FRAMES(FRAMES),
        .COUNT_W(COUNT_W)
    ) dut0 (
        .clk(clk),
        .combin_res(combin_res),
        .photon_valid(photon_valid),
        .photon_ready(photon_ready),
        .photon_bin(photon_bin),
        .hist_valid(hist_valid),
        .hist_ready(hist_ready),
        .hist_pixel(hist_pixel),
        .hist_bin(hist_bin),
        .hist_count(hist_count),
        .hist_last(hist_last),
        .hist_num(hist_num)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic report_value(input string name, input logic [31:0] seen,
                                input logic [31:0] want);
        value_errs++;
        $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, seen, want);
    endtask

    function automatic int next_count(input int c);
        return (c >= MAX_CNT) ? MAX_CNT : c + 1;
    endfunction

    function automatic logic [BIN_W-1:0] bin_for(input int mode, input int pix,
                                                 input int frm, input int smp);
        int b;
        case (mode)
            MODE_RAMP:   b = pix * 2 + frm * SPP + smp;
            MODE_NARROW: b = 4 + (pix + smp) % 2;
            // pixel 2 piles all 9 samples onto bin 5
            MODE_SAT:    b = (pix == 2) ? 5 : pix + frm + smp;
            default:     b = int'($urandom_range(0, BINS - 1));
        endcase
        return BIN_W'(b % BINS);
    endfunction

    task automatic clear_model();
        for (int p = 0; p < PIXELS; p++) begin
            for (int b = 0; b < BINS; b++) begin
                model[p][b] = 0;
            end
        end
    endtask

    // offer one photon from a falling edge, hold it until taken
    task automatic send_photon(input logic [BIN_W-1:0] b);
        int pix;
        pix = (smp_idx % PER_FRAME) / SPP;
        photon_valid = 1'b1;
        photon_bin = b;
        while (!photon_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        photon_valid = 1'b0;
        model[pix][b] = next_count(model[pix][b]);
        smp_idx++;
        if (smp_idx == PER_PERIOD) begin
            expect_hist = model;
            clear_model();
            smp_idx = 0;
        end
    endtask

    // photons up to and including the closing one of the period
    task automatic run_period(input int mode, input bit gaps);
        int frm;
        int pix;
        int smp;
        do begin
            if (gaps) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
            end
            frm = smp_idx / PER_FRAME;
            pix = (smp_idx % PER_FRAME) / SPP;
            smp = smp_idx % SPP;
            send_photon(bin_for(mode, pix, frm, smp));
        end while (smp_idx != 0);
        if (photon_ready) begin
            other_errs++;
            $display("photon_ready still high after the closing photon");
        end
    endtask

    // drain order is lane, local pixel, bin
    task automatic collect_period(input bit rand_ready);
        int n;
        int lane;
        int rem;
        int pix;
        int bin;
        n = 0;
        while (n < WORDS) begin
            hist_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
            if (hist_valid && hist_ready) begin
                lane = n / (LPIX * BINS);
                rem = n % (LPIX * BINS);
                pix = (rem / BINS) * N_LANES + lane;
                bin = rem % BINS;
                if (hist_pixel !== GPIX_W'(pix)) report_value("hist_pixel", hist_pixel, pix);
                if (hist_bin !== BIN_W'(bin)) report_value("hist_bin", hist_bin, bin);
                if (hist_count !== COUNT_W'(expect_hist[pix][bin])) begin
                    report_value("hist_count", hist_count, expect_hist[pix][bin]);
                end
                if (hist_last !== (n == WORDS - 1)) begin
                    report_value("hist_last", hist_last, n == WORDS - 1);
                end
                got[pix][bin] = int'(hist_count);
                n++;
            end
            @(negedge clk);
        end
        hist_ready = 1'b0;
        exp_num = ~exp_num;
        if (hist_num !== exp_num) report_value("hist_num", hist_num, exp_num);
        if (hist_valid) begin
            other_errs++;
            $display("another word offered after the closing word");
        end
    endtask

    task automatic test_single_period();
        run_period(MODE_RAMP, 1'b0);
        collect_period(1'b0);
    endtask

    // pixel 0 bin 0 was hit in the ramp period only
    task automatic test_lazy_clear();
        run_period(MODE_NARROW, 1'b0);
        collect_period(1'b0);
        if (got[0][0] != 0) begin
            other_errs++;
            $display("stale count left in pixel 0 bin 0 after the period change");
        end
    endtask

    task automatic test_saturation();
        run_period(MODE_SAT, 1'b0);
        collect_period(1'b0);
        if (got[2][5] != MAX_CNT) report_value("hist_count", got[2][5], MAX_CNT);
    endtask

    task automatic test_random_flow();
        run_period(MODE_RAND, 1'b1);
        collect_period(1'b1);
    endtask

    // first photon of the next period, offered while lane 0 drains
    task automatic offer_during_drain();
        repeat (3) @(negedge clk);
        if (photon_ready) begin
            other_errs++;
            $display("photon_ready high while lane 0 was draining");
        end
        send_photon(BIN_W'(3));
    endtask

    task automatic test_drain_stall();
        run_period(MODE_RAMP, 1'b0);
        fork
            collect_period(1'b0);
            offer_during_drain();
        join
        run_period(MODE_RAMP, 1'b0);
        collect_period(1'b0);
    endtask

    initial begin
        void'($urandom(SEED));
        photon_valid = 1'b0;
        photon_bin = '0;
        hist_ready = 1'b0;
        smp_idx = 0;
        exp_num = 1'b0;
        value_errs = 0;
        other_errs = 0;
        clear_model();
        expect_hist = model;
        got = model;
        @(posedge combin_res);
        @(negedge clk);
        if (hist_valid !== 1'b0) report_value("hist_valid", hist_valid, 0);
        if (hist_last !== 1'b0) report_value("hist_last", hist_last, 0);
        if (hist_num !== 1'b0) report_value("hist_num", hist_num, 0);
        if (photon_ready !== 1'b1) report_value("photon_ready", photon_ready, 1);
        test_single_period();
        test_lazy_clear();
        test_saturation();
        test_random_flow();
        test_drain_stall();
        other_errs += dut0.u_hist_assert.fail_cnt;
        $display("value errors %0d, other errors %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- hist_builder.f
rtl/hist_pkg.sv
rtl/hist_if.sv
rtl/photon_dispatch.sv
rtl/hist_lane.sv
rtl/hist_readout.sv
rtl/hist_top.sv
testbench/tb_clkgen.sv
testbench/hist_assert.sv
testbench/hist_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := hist_tb
FILELIST  := hist_builder.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Regression passed

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output stays on the terminal, status comes from the pass search
run: $(SIM)
	./$(SIM) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
